//--- rtl/issue_pkg.sv
package issue_pkg;

  // Architectural register address, x0 reads as zero
  typedef logic [4:0] reg_addr_t;

  // Decoded operation flags
  typedef logic [4:0] op_flags_t;

  localparam int OP_RDEN1 = 0;  // Reads source 1
  localparam int OP_RDEN2 = 1;  // Reads source 2
  localparam int OP_WREN  = 2;  // Writes destination
  localparam int OP_LOAD  = 3;
  localparam int OP_DIV   = 4;

  // No flags set means a bubble
  localparam op_flags_t OP_NONE = '0;

  // Divider occupancy after a divide issues
  localparam int DIV_CYCLES = 4;
  localparam int TIMER_W    = 3;

  typedef enum logic {
    S_PAIR,   // Normal paired issue
    S_SPLIT   // Held slot 1 goes out alone in slot 0
  } issue_state_t;

endpackage

//--- rtl/issue_select.sv
`timescale 1ns/1ps

module issue_select import issue_pkg::*; (
  input  logic         in0_valid,
  input  logic         in1_valid,
  input  op_flags_t    in0_op,
  input  op_flags_t    in1_op,
  input  reg_addr_t    in0_raddr1,
  input  reg_addr_t    in0_raddr2,
  input  reg_addr_t    in0_waddr,
  input  reg_addr_t    in1_raddr1,
  input  reg_addr_t    in1_raddr2,
  input  reg_addr_t    in1_waddr,
  input  issue_state_t state,
  output op_flags_t    cand0_op,
  output reg_addr_t    cand0_raddr1,
  output reg_addr_t    cand0_raddr2,
  output reg_addr_t    cand0_waddr,
  output op_flags_t    cand1_op,
  output reg_addr_t    cand1_raddr1,
  output reg_addr_t    cand1_raddr2,
  output reg_addr_t    cand1_waddr,
  output logic         need_split
);

  logic in0_writes;
  logic raw_dep;
  logic pair_ok;

  assign in0_writes = in0_op[OP_WREN] && (in0_waddr != '0);  // Writes to x0 are harmless

  assign raw_dep = in0_writes &&
                   ((in1_op[OP_RDEN1] && (in1_raddr1 == in0_waddr)) ||
                    (in1_op[OP_RDEN2] && (in1_raddr2 == in0_waddr)));

  // Only one divider, and it is fed from slot 0
  assign pair_ok = in0_valid && !in1_op[OP_DIV] &&
                   !(in0_op[OP_LOAD] && in1_op[OP_LOAD]) && !raw_dep;

  assign need_split = (state == S_PAIR) && in1_valid && !pair_ok;

  always_comb begin
    cand0_op     = OP_NONE;
    cand0_raddr1 = '0;
    cand0_raddr2 = '0;
    cand0_waddr  = '0;
    cand1_op     = OP_NONE;
    cand1_raddr1 = '0;
    cand1_raddr2 = '0;
    cand1_waddr  = '0;
    if (state == S_SPLIT) begin
      if (in1_valid) begin  // Second half of a split pair
        cand0_op     = in1_op;
        cand0_raddr1 = in1_raddr1;
        cand0_raddr2 = in1_raddr2;
        cand0_waddr  = in1_waddr;
      end
    end else begin
      if (in0_valid) begin
        cand0_op     = in0_op;
        cand0_raddr1 = in0_raddr1;
        cand0_raddr2 = in0_raddr2;
        cand0_waddr  = in0_waddr;
      end
      if (in1_valid && pair_ok) begin
        cand1_op     = in1_op;
        cand1_raddr1 = in1_raddr1;
        cand1_raddr2 = in1_raddr2;
        cand1_waddr  = in1_waddr;
      end
    end
  end

endmodule

//--- rtl/operand_hazard.sv
`timescale 1ns/1ps

module operand_hazard import issue_pkg::*; (
  input  op_flags_t cand0_op,
  input  op_flags_t cand1_op,
  input  op_flags_t ex0_op,
  input  op_flags_t ex1_op,
  input  reg_addr_t cand0_raddr1,
  input  reg_addr_t cand0_raddr2,
  input  reg_addr_t cand1_raddr1,
  input  reg_addr_t cand1_raddr2,
  input  reg_addr_t ex0_waddr,
  input  reg_addr_t ex1_waddr,
  input  logic      div_busy,
  output logic      hazard
);

  logic [7:0] hits;

  // Load result not ready for a source read in the next cycle
  function automatic logic load_hit(
    input op_flags_t ex_op,
    input reg_addr_t ex_waddr,
    input logic      rden,
    input reg_addr_t raddr
  );
    logic dst_live;
    dst_live = ex_op[OP_LOAD] && (ex_waddr != '0);
    return dst_live && rden && (raddr == ex_waddr);
  endfunction

  always_comb begin
    // Slot 0 sources against both execute slots
    hits[0] = load_hit(ex0_op, ex0_waddr, cand0_op[OP_RDEN1], cand0_raddr1);
    hits[1] = load_hit(ex0_op, ex0_waddr, cand0_op[OP_RDEN2], cand0_raddr2);
    hits[2] = load_hit(ex1_op, ex1_waddr, cand0_op[OP_RDEN1], cand0_raddr1);
    hits[3] = load_hit(ex1_op, ex1_waddr, cand0_op[OP_RDEN2], cand0_raddr2);
    // Slot 1 sources
    hits[4] = load_hit(ex0_op, ex0_waddr, cand1_op[OP_RDEN1], cand1_raddr1);
    hits[5] = load_hit(ex0_op, ex0_waddr, cand1_op[OP_RDEN2], cand1_raddr2);
    hits[6] = load_hit(ex1_op, ex1_waddr, cand1_op[OP_RDEN1], cand1_raddr1);
    hits[7] = load_hit(ex1_op, ex1_waddr, cand1_op[OP_RDEN2], cand1_raddr2);
  end

  assign hazard = div_busy || (|hits);

endmodule

//--- rtl/divide_timer.sv
`timescale 1ns/1ps

module divide_timer import issue_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic div_start,
  output logic div_busy
);

  logic [TIMER_W-1:0] count;

  // Runs on its own once loaded, execute stalls do not pause the divider
  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else if (div_start) begin
      count <= TIMER_W'(DIV_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign div_busy = (count != '0);

endmodule

//--- rtl/issue_fsm.sv
`timescale 1ns/1ps

module issue_fsm import issue_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         need_split,
  input  logic         hazard,
  input  logic         ex_stall,
  input  logic         flush,
  output issue_state_t state,
  output logic         advance,
  output logic         bubble,
  output logic         dec_stall
);

  issue_state_t state_next;

  assign advance = !hazard && !ex_stall && !flush;

  // Hazard inserts a bubble, back-pressure freezes the latch instead
  assign bubble = hazard && !ex_stall;

  // Decoder must hold its pair until the split finishes
  assign dec_stall = hazard || ex_stall || ((state == S_PAIR) && need_split);

  always_comb begin
    state_next = state;
    if (flush) begin
      state_next = S_PAIR;
    end else if (advance) begin
      case (state)
        S_PAIR: begin
          if (need_split) begin
            state_next = S_SPLIT;
          end
        end
        S_SPLIT: begin
          state_next = S_PAIR;  // Held slot 1 has gone out
        end
        default: begin
          state_next = S_PAIR;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= S_PAIR;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- rtl/issue_latch.sv
`timescale 1ns/1ps

module issue_latch import issue_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      advance,
  input  logic      bubble,
  input  logic      flush,
  input  op_flags_t cand0_op,
  input  op_flags_t cand1_op,
  input  reg_addr_t cand0_waddr,
  input  reg_addr_t cand1_waddr,
  output op_flags_t ex0_op,
  output op_flags_t ex1_op,
  output reg_addr_t ex0_waddr,
  output reg_addr_t ex1_waddr
);

  // Execute-stage instruction pair
  always_ff @(posedge clock) begin
    if (!reset) begin
      ex0_op    <= OP_NONE;
      ex1_op    <= OP_NONE;
      ex0_waddr <= '0;
      ex1_waddr <= '0;
    end else if (flush || bubble) begin
      // Squashed or stalled pair leaves a bubble behind
      ex0_op    <= OP_NONE;
      ex1_op    <= OP_NONE;
      ex0_waddr <= '0;
      ex1_waddr <= '0;
    end else if (advance) begin
      ex0_op    <= cand0_op;
      ex1_op    <= cand1_op;
      ex0_waddr <= cand0_waddr;
      ex1_waddr <= cand1_waddr;
    end
    // Otherwise hold under back-pressure
  end

endmodule

//--- rtl/issue_unit.sv
`timescale 1ns/1ps

module issue_unit import issue_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       in0_valid,
  input  op_flags_t  in0_op,
  input  reg_addr_t  in0_raddr1,
  input  reg_addr_t  in0_raddr2,
  input  reg_addr_t  in0_waddr,
  input  logic       in1_valid,
  input  op_flags_t  in1_op,
  input  reg_addr_t  in1_raddr1,
  input  reg_addr_t  in1_raddr2,
  input  reg_addr_t  in1_waddr,
  input  logic       ex_stall,
  input  logic       flush,
  output logic       dec_stall,
  output logic [3:0] rf_rden,
  output reg_addr_t  rf_raddr0a,
  output reg_addr_t  rf_raddr0b,
  output reg_addr_t  rf_raddr1a,
  output reg_addr_t  rf_raddr1b,
  output op_flags_t  ex0_op,
  output reg_addr_t  ex0_waddr,
  output op_flags_t  ex1_op,
  output reg_addr_t  ex1_waddr
);

  op_flags_t    cand0_op;
  op_flags_t    cand1_op;
  reg_addr_t    cand0_raddr1;
  reg_addr_t    cand0_raddr2;
  reg_addr_t    cand0_waddr;
  reg_addr_t    cand1_raddr1;
  reg_addr_t    cand1_raddr2;
  reg_addr_t    cand1_waddr;
  logic         need_split;
  logic         hazard;
  logic         div_busy;
  logic         div_start;
  issue_state_t state;
  logic         advance;
  logic         bubble;

  issue_select u_select (
    .in0_valid, .in1_valid, .in0_op, .in1_op,
    .in0_raddr1, .in0_raddr2, .in0_waddr,
    .in1_raddr1, .in1_raddr2, .in1_waddr, .state,
    .cand0_op, .cand0_raddr1, .cand0_raddr2, .cand0_waddr,
    .cand1_op, .cand1_raddr1, .cand1_raddr2, .cand1_waddr, .need_split
  );

  operand_hazard u_hazard (
    .cand0_op, .cand1_op, .ex0_op, .ex1_op,
    .cand0_raddr1, .cand0_raddr2, .cand1_raddr1, .cand1_raddr2,
    .ex0_waddr, .ex1_waddr, .div_busy, .hazard
  );

  // Divides only ever issue from slot 0
  assign div_start = advance && cand0_op[OP_DIV];

  divide_timer u_timer (.clock, .reset, .flush, .div_start, .div_busy);

  issue_fsm u_fsm (
    .clock, .reset, .need_split, .hazard, .ex_stall, .flush,
    .state, .advance, .bubble, .dec_stall
  );

  issue_latch u_latch (
    .clock, .reset, .advance, .bubble, .flush,
    .cand0_op, .cand1_op, .cand0_waddr, .cand1_waddr,
    .ex0_op, .ex1_op, .ex0_waddr, .ex1_waddr
  );

  // Register file read ports, bubbles read nothing
  assign rf_rden = {cand1_op[OP_RDEN2], cand1_op[OP_RDEN1],
                    cand0_op[OP_RDEN2], cand0_op[OP_RDEN1]};
  assign rf_raddr0a = cand0_op[OP_RDEN1] ? cand0_raddr1 : '0;
  assign rf_raddr0b = cand0_op[OP_RDEN2] ? cand0_raddr2 : '0;
  assign rf_raddr1a = cand1_op[OP_RDEN1] ? cand1_raddr1 : '0;
  assign rf_raddr1b = cand1_op[OP_RDEN2] ? cand1_raddr2 : '0;

endmodule

//--- dv/issue_unit_tb.sv
`timescale 1ns/1ps

module issue_unit_tb import issue_pkg::*; ();

  localparam int PERIOD      = 40;
  localparam int DEPTH       = 64;
  localparam int FIELDS      = 23;
  localparam int ROW_W       = FIELDS * 8;
  localparam int RESET_LIMIT = 20;

  logic       clock;
  logic       reset;
  logic       in0_valid;
  op_flags_t  in0_op;
  reg_addr_t  in0_raddr1;
  reg_addr_t  in0_raddr2;
  reg_addr_t  in0_waddr;
  logic       in1_valid;
  op_flags_t  in1_op;
  reg_addr_t  in1_raddr1;
  reg_addr_t  in1_raddr2;
  reg_addr_t  in1_waddr;
  logic       ex_stall;
  logic       flush;
  logic       dec_stall;
  logic [3:0] rf_rden;
  reg_addr_t  rf_raddr0a;
  reg_addr_t  rf_raddr0b;
  reg_addr_t  rf_raddr1a;
  reg_addr_t  rf_raddr1b;
  op_flags_t  ex0_op;
  reg_addr_t  ex0_waddr;
  op_flags_t  ex1_op;
  reg_addr_t  ex1_waddr;

  logic [ROW_W-1:0] patterns [0:DEPTH-1];
  logic [7:0]       fld [0:FIELDS-1];  // One byte per column of the current row
  int               test_errors;
  int               tests_passed;
  int               tests_failed;

  issue_unit u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clock);
    #2 reset = 1'b1;
  end

  task automatic check_op(input string name, input op_flags_t expected, input op_flags_t actual);
    if (actual !== expected) begin
      $display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t expected,
                            input reg_addr_t actual);
    if (actual !== expected) begin
      $display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_rden(input logic [3:0] expected, input logic [3:0] actual);
    if (actual !== expected) begin
      $display("Fail rf_rden expected 0x%h actual 0x%h", expected, actual);
      test_errors++;
    end
  endtask

  task automatic unpack_row(input int idx);
    for (int i = 0; i < FIELDS; i++) begin
      fld[i] = patterns[idx][ROW_W-1-8*i -: 8];
    end
  endtask

  task automatic drive_row();
    in0_valid  = fld[1][0];
    in0_op     = fld[2][4:0];
    in0_raddr1 = fld[3][4:0];
    in0_raddr2 = fld[4][4:0];
    in0_waddr  = fld[5][4:0];
    in1_valid  = fld[6][0];
    in1_op     = fld[7][4:0];
    in1_raddr1 = fld[8][4:0];
    in1_raddr2 = fld[9][4:0];
    in1_waddr  = fld[10][4:0];
    ex_stall   = fld[11][0];
    flush      = fld[12][0];
  endtask

  // Stall and read requests settle within the cycle
  task automatic check_comb();
    check_bit("dec_stall", fld[13][0], dec_stall);
    check_rden(fld[14][3:0], rf_rden);
    check_addr("rf_raddr0a", fld[15][4:0], rf_raddr0a);
    check_addr("rf_raddr0b", fld[16][4:0], rf_raddr0b);
    check_addr("rf_raddr1a", fld[17][4:0], rf_raddr1a);
    check_addr("rf_raddr1b", fld[18][4:0], rf_raddr1b);
  endtask

  task automatic check_ex();
    check_op("ex0_op", fld[19][4:0], ex0_op);
    check_addr("ex0_waddr", fld[20][4:0], ex0_waddr);
    check_op("ex1_op", fld[21][4:0], ex1_op);
    check_addr("ex1_waddr", fld[22][4:0], ex1_waddr);
  endtask

  task automatic finish_test(input int number);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d ok", number);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d mismatches", number, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin : main
    int idx;
    int cycles;
    int current_test;
    in0_valid    = 1'b0;
    in0_op       = OP_NONE;
    in0_raddr1   = '0;
    in0_raddr2   = '0;
    in0_waddr    = '0;
    in1_valid    = 1'b0;
    in1_op       = OP_NONE;
    in1_raddr1   = '0;
    in1_raddr2   = '0;
    in1_waddr    = '0;
    ex_stall     = 1'b0;
    flush        = 1'b0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    $readmemh("dv/issue_patterns.txt", patterns);

    cycles = 0;
    @(posedge clock);
    while (reset !== 1'b1 && cycles < RESET_LIMIT) begin
      @(posedge clock);
      cycles++;
    end

    if (reset !== 1'b1) begin
      $display("Error: reset never released");
      $display("TEST FAIL");
      $finish;
    end else begin
      #2;
      idx = 0;
      current_test = -1;
      // Row with test number ff ends the table
      while (idx < DEPTH && !$isunknown(patterns[idx]) &&
             patterns[idx][ROW_W-1 -: 8] != 8'hff) begin
        unpack_row(idx);
        if (int'(fld[0]) != current_test) begin
          if (current_test >= 0) finish_test(current_test);
          current_test = int'(fld[0]);
        end
        drive_row();
        #(PERIOD - 3);  // Just before the edge
        check_comb();
        #2;             // Just after the edge
        check_ex();
        #1;
        idx++;
      end
      if (current_test >= 0) finish_test(current_test);
      if (tests_passed + tests_failed == 0) begin
        $display("Error: no patterns were loaded");
      end
      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && tests_passed > 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

//--- issue_unit.f
rtl/issue_pkg.sv
rtl/issue_select.sv
rtl/operand_hazard.sv
rtl/divide_timer.sv
rtl/issue_fsm.sv
rtl/issue_latch.sv
rtl/issue_unit.sv
dv/issue_unit_tb.sv

//--- dv/issue_patterns.txt
// test v0 op0 ra1 ra2 wa0 v1 op1 ra1 ra2 wa1 ex_stall flush | dec_stall rf_rden
// rf_raddr0a 0b 1a 1b | ex0_op ex0_waddr ex1_op ex1_waddr (one cycle per row)
// Reset leaves bubbles and no stall
01_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
// Independent pairs
02_01_07_01_02_03_01_07_04_05_06_00_00_00_0f_01_02_04_05_07_03_07_06
02_01_05_03_09_07_01_07_06_08_09_00_00_00_0d_03_00_06_08_05_07_07_09
// Slot 1 reads slot 0 destination
03_01_07_01_02_0a_01_07_0a_04_0b_00_00_01_03_01_02_00_00_07_0a_00_00
03_01_07_01_02_0a_01_07_0a_04_0b_00_00_00_03_0a_04_00_00_07_0b_00_00
// Two loads
04_01_0d_01_00_0c_01_0d_02_00_0d_00_00_01_01_01_00_00_00_0d_0c_00_00
04_01_0d_01_00_0c_01_0d_02_00_0d_00_00_00_01_02_00_00_00_0d_0d_00_00
// Load use against ex slot 0, then against ex slot 1
05_01_07_0d_01_0e_01_05_02_00_0f_00_00_01_07_0d_01_02_00_00_00_00_00
05_01_07_0d_01_0e_01_05_02_00_0f_00_00_00_07_0d_01_02_00_07_0e_05_0f
05_01_05_01_00_10_01_0d_02_00_11_00_00_00_05_01_00_02_00_05_10_0d_11
05_01_03_03_04_00_01_07_11_05_12_00_00_01_0f_03_04_11_05_00_00_00_00
05_01_03_03_04_00_01_07_11_05_12_00_00_00_0f_03_04_11_05_03_00_07_12
// Divide in slot 1 splits
06_01_07_01_02_13_01_17_03_04_14_00_00_01_03_01_02_00_00_07_13_00_00
06_01_07_01_02_13_01_17_03_04_14_00_00_00_03_03_04_00_00_17_14_00_00
// Divider busy for four cycles
07_01_07_05_06_15_01_07_07_08_16_00_00_01_0f_05_06_07_08_00_00_00_00
07_01_07_05_06_15_01_07_07_08_16_00_00_01_0f_05_06_07_08_00_00_00_00
07_01_07_05_06_15_01_07_07_08_16_00_00_01_0f_05_06_07_08_00_00_00_00
07_01_07_05_06_15_01_07_07_08_16_00_00_01_0f_05_06_07_08_00_00_00_00
07_01_07_05_06_15_01_07_07_08_16_00_00_00_0f_05_06_07_08_07_15_07_16
// Back-pressure in the middle of a split
08_01_07_01_02_17_01_07_17_03_18_00_00_01_03_01_02_00_00_07_17_00_00
08_01_07_01_02_17_01_07_17_03_18_01_00_01_03_17_03_00_00_07_17_00_00
08_01_07_01_02_17_01_07_17_03_18_01_00_01_03_17_03_00_00_07_17_00_00
08_01_07_01_02_17_01_07_17_03_18_00_00_00_03_17_03_00_00_07_18_00_00
// Flush in the middle of a split
09_01_0d_01_00_19_01_0d_02_00_1a_00_00_01_01_01_00_00_00_0d_19_00_00
09_01_0d_01_00_19_01_0d_02_00_1a_00_01_00_01_02_00_00_00_00_00_00_00
09_01_07_01_02_1b_01_07_03_04_1c_00_00_00_0f_01_02_03_04_07_1b_07_1c
// Flush while the divider is busy
0a_01_17_01_02_1d_01_07_03_04_1e_00_00_00_0f_01_02_03_04_17_1d_07_1e
0a_01_07_05_06_1f_01_07_07_08_01_00_00_01_0f_05_06_07_08_00_00_00_00
0a_01_07_05_06_1f_01_07_07_08_01_00_01_01_0f_05_06_07_08_00_00_00_00
0a_01_07_05_06_1f_01_07_07_08_01_00_00_00_0f_05_06_07_08_07_1f_07_01
// Invalid slot 0, then an empty pair
0b_00_07_09_09_09_01_07_01_02_02_00_00_01_00_00_00_00_00_00_00_00_00
0b_00_07_09_09_09_01_07_01_02_02_00_00_00_03_01_02_00_00_07_02_00_00
0b_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
// End of table
ff_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
